/* rtl/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data path and address width.
`define CPU_XLEN 32

// architectural register count, r0 included.
`define CPU_NREGS 32

// first instruction fetched after reset.
`define CPU_RESET_PC 32'h1c00_0000

`endif

/* rtl/isa_pkg.sv */
`include "cpu_defs.svh"

package isa_pkg;

    // the supported LA32R subset.
    typedef enum logic [4:0] {
        op_add_w,
        op_sub_w,
        op_slt,
        op_sltu,
        op_nor,
        op_and,
        op_or,
        op_xor,
        op_slli_w,
        op_srli_w,
        op_srai_w,
        op_addi_w,
        op_ld_w,
        op_st_w,
        op_jirl,
        op_b,
        op_bl,
        op_beq,
        op_bne,
        op_lu12i_w,
        op_invalid
    } inst_op_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef struct packed {
        inst_op_e                        op;
        alu_op_e                         alu_op;
        logic [$clog2(`CPU_NREGS)-1:0]   rj;
        logic [$clog2(`CPU_NREGS)-1:0]   rk_or_rd;
        logic [$clog2(`CPU_NREGS)-1:0]   dest;
        logic [`CPU_XLEN-1:0]            imm;
        logic [`CPU_XLEN-1:0]            br_offs;
        logic                            src1_is_pc;
        logic                            src2_is_imm;
        logic                            writes_rf;
    } decoded_inst_t;

endpackage

/* rtl/core_pkg.sv */
`include "cpu_defs.svh"

package core_pkg;

    // one instruction walks through these, skipping what it does not need.
    typedef enum logic [2:0] {
        st_if,
        st_id,
        st_exe,
        st_mem,
        st_wb
    } core_state_e;

    typedef struct packed {
        logic                            valid;
        logic [`CPU_XLEN-1:0]            pc;
        logic [$clog2(`CPU_NREGS)-1:0]   wnum;
        logic [`CPU_XLEN-1:0]            wdata;
    } wb_trace_t;

endpackage

/* rtl/inst_decoder.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module inst_decoder (
    input  logic [`CPU_XLEN-1:0]    inst,
    output isa_pkg::decoded_inst_t  dec
);

    isa_pkg::inst_op_e              op;
    logic [5:0]                     op_31_26;
    logic [3:0]                     op_25_22;
    logic [1:0]                     op_21_20;
    logic [4:0]                     op_19_15;
    logic [$clog2(`CPU_NREGS)-1:0]  rd;
    logic [$clog2(`CPU_NREGS)-1:0]  rj;
    logic [$clog2(`CPU_NREGS)-1:0]  rk;
    logic [`CPU_XLEN-1:0]           si12;
    logic [`CPU_XLEN-1:0]           si16;
    logic [`CPU_XLEN-1:0]           si20;
    logic [`CPU_XLEN-1:0]           si26;
    logic [`CPU_XLEN-1:0]           ui5;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    // branch offsets are word offsets, so they come out already shifted.
    assign si12 = {{20{inst[21]}}, inst[21:10]};
    assign si16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign si20 = {inst[24:5], 12'b0};
    assign si26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    assign ui5  = {27'b0, inst[14:10]};

    always_comb begin
        op = isa_pkg::op_invalid;
        if (op_31_26 == 6'h00 && op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
            case (op_19_15)
                5'h00: op = isa_pkg::op_add_w;
                5'h02: op = isa_pkg::op_sub_w;
                5'h04: op = isa_pkg::op_slt;
                5'h05: op = isa_pkg::op_sltu;
                5'h08: op = isa_pkg::op_nor;
                5'h09: op = isa_pkg::op_and;
                5'h0a: op = isa_pkg::op_or;
                5'h0b: op = isa_pkg::op_xor;
                default: op = isa_pkg::op_invalid;
            endcase
        end else if (op_31_26 == 6'h00 && op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
            case (op_19_15)
                5'h01: op = isa_pkg::op_slli_w;
                5'h09: op = isa_pkg::op_srli_w;
                5'h11: op = isa_pkg::op_srai_w;
                default: op = isa_pkg::op_invalid;
            endcase
        end else if (op_31_26 == 6'h00 && op_25_22 == 4'ha) begin
            op = isa_pkg::op_addi_w;
        end else if (op_31_26 == 6'h0a && op_25_22 == 4'h2) begin
            op = isa_pkg::op_ld_w;
        end else if (op_31_26 == 6'h0a && op_25_22 == 4'h6) begin
            op = isa_pkg::op_st_w;
        end else if (op_31_26 == 6'h05 && !inst[25]) begin
            op = isa_pkg::op_lu12i_w;
        end else begin
            case (op_31_26)
                6'h13: op = isa_pkg::op_jirl;
                6'h14: op = isa_pkg::op_b;
                6'h15: op = isa_pkg::op_bl;
                6'h16: op = isa_pkg::op_beq;
                6'h17: op = isa_pkg::op_bne;
                default: op = isa_pkg::op_invalid;
            endcase
        end
    end

    always_comb begin
        dec = '0;
        dec.op = op;
        dec.alu_op = isa_pkg::alu_add;
        dec.rj = rj;
        dec.br_offs = si16;
        // stores and compares read rd as the second source.
        if (op == isa_pkg::op_st_w || op == isa_pkg::op_beq || op == isa_pkg::op_bne) begin
            dec.rk_or_rd = rd;
        end else begin
            dec.rk_or_rd = rk;
        end
        dec.dest = (op == isa_pkg::op_bl) ? 5'd1 : rd;
        case (op)
            isa_pkg::op_add_w: dec.writes_rf = 1'b1;
            isa_pkg::op_sub_w: begin
                dec.alu_op = isa_pkg::alu_sub;
                dec.writes_rf = 1'b1;
            end
            isa_pkg::op_slt: begin
                dec.alu_op = isa_pkg::alu_slt;
                dec.writes_rf = 1'b1;
            end
            isa_pkg::op_sltu: begin
                dec.alu_op = isa_pkg::alu_sltu;
                dec.writes_rf = 1'b1;
            end
            isa_pkg::op_nor: begin
                dec.alu_op = isa_pkg::alu_nor;
                dec.writes_rf = 1'b1;
            end
            isa_pkg::op_and: begin
                dec.alu_op = isa_pkg::alu_and;
                dec.writes_rf = 1'b1;
            end
            isa_pkg::op_or: begin
                dec.alu_op = isa_pkg::alu_or;
                dec.writes_rf = 1'b1;
            end
            isa_pkg::op_xor: begin
                dec.alu_op = isa_pkg::alu_xor;
                dec.writes_rf = 1'b1;
            end
            isa_pkg::op_slli_w, isa_pkg::op_srli_w, isa_pkg::op_srai_w: begin
                if (op == isa_pkg::op_slli_w) begin
                    dec.alu_op = isa_pkg::alu_sll;
                end else if (op == isa_pkg::op_srli_w) begin
                    dec.alu_op = isa_pkg::alu_srl;
                end else begin
                    dec.alu_op = isa_pkg::alu_sra;
                end
                dec.imm = ui5;
                dec.src2_is_imm = 1'b1;
                dec.writes_rf = 1'b1;
            end
            isa_pkg::op_addi_w, isa_pkg::op_ld_w, isa_pkg::op_st_w: begin
                dec.imm = si12;
                dec.src2_is_imm = 1'b1;
                dec.writes_rf = (op != isa_pkg::op_st_w);
            end
            isa_pkg::op_jirl, isa_pkg::op_bl: begin
                // link value is pc + 4.
                dec.imm = 32'd4;
                dec.src1_is_pc = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.writes_rf = 1'b1;
                dec.br_offs = (op == isa_pkg::op_bl) ? si26 : si16;
            end
            isa_pkg::op_b: dec.br_offs = si26;
            isa_pkg::op_lu12i_w: begin
                dec.alu_op = isa_pkg::alu_lui;
                dec.imm = si20;
                dec.src2_is_imm = 1'b1;
                dec.writes_rf = 1'b1;
            end
            default: dec.writes_rf = 1'b0;
        endcase
    end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module regfile (
    input  logic                             clk,
    input  logic [$clog2(`CPU_NREGS)-1:0]    raddr1,
    input  logic [$clog2(`CPU_NREGS)-1:0]    raddr2,
    input  logic [$clog2(`CPU_NREGS)-1:0]    waddr,
    input  logic                             we,
    input  logic [`CPU_XLEN-1:0]             wdata,
    output logic [`CPU_XLEN-1:0]             rdata1,
    output logic [`CPU_XLEN-1:0]             rdata2
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    // r0 is never written.
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* rtl/alu.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module alu (
    input  isa_pkg::alu_op_e        alu_op,
    input  logic [`CPU_XLEN-1:0]    src1,
    input  logic [`CPU_XLEN-1:0]    src2,
    output logic [`CPU_XLEN-1:0]    result
);

    logic [$clog2(`CPU_XLEN)-1:0] shamt;
    logic                         lt_signed;
    logic                         lt_unsigned;

    assign shamt = src2[$clog2(`CPU_XLEN)-1:0];
    assign lt_signed = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (alu_op)
            isa_pkg::alu_add: result = src1 + src2;
            isa_pkg::alu_sub: result = src1 - src2;
            isa_pkg::alu_slt: result = {{(`CPU_XLEN-1){1'b0}}, lt_signed};
            isa_pkg::alu_sltu: result = {{(`CPU_XLEN-1){1'b0}}, lt_unsigned};
            isa_pkg::alu_and: result = src1 & src2;
            isa_pkg::alu_nor: result = ~(src1 | src2);
            isa_pkg::alu_or: result = src1 | src2;
            isa_pkg::alu_xor: result = src1 ^ src2;
            isa_pkg::alu_sll: result = src1 << shamt;
            isa_pkg::alu_srl: result = src1 >> shamt;
            isa_pkg::alu_sra: result = $signed(src1) >>> shamt;
            // lu12i.w takes the shifted immediate straight through.
            isa_pkg::alu_lui: result = src2;
            default: result = '0;
        endcase
    end

endmodule

/* rtl/multicycle_core.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module multicycle_core (
    input  logic                    clk,
    input  logic                    reset,
    output logic [`CPU_XLEN-1:0]    inst_addr,
    input  logic [`CPU_XLEN-1:0]    inst_rdata,
    output logic                    data_we,
    output logic [`CPU_XLEN-1:0]    data_addr,
    output logic [`CPU_XLEN-1:0]    data_wdata,
    input  logic [`CPU_XLEN-1:0]    data_rdata,
    output core_pkg::wb_trace_t     wb_trace
);

    core_pkg::core_state_e  state;
    core_pkg::core_state_e  state_next;
    isa_pkg::decoded_inst_t dec;

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] ir;
    logic [`CPU_XLEN-1:0] rj_value;
    logic [`CPU_XLEN-1:0] rkd_value;
    logic [`CPU_XLEN-1:0] alu_src1;
    logic [`CPU_XLEN-1:0] alu_src2;
    logic [`CPU_XLEN-1:0] alu_result;
    logic [`CPU_XLEN-1:0] seq_pc;
    logic [`CPU_XLEN-1:0] br_target;
    logic [`CPU_XLEN-1:0] next_pc;
    logic [`CPU_XLEN-1:0] wb_value;
    logic                 br_taken;
    logic                 id_only;
    logic                 is_mem;
    logic                 rf_we;

    inst_decoder u_inst_decoder (
        .inst (ir),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.rj),
        .raddr2 (dec.rk_or_rd),
        .waddr  (dec.dest),
        .we     (rf_we),
        .wdata  (wb_value),
        .rdata1 (rj_value),
        .rdata2 (rkd_value)
    );

    assign alu_src1 = dec.src1_is_pc ? pc : rj_value;
    assign alu_src2 = dec.src2_is_imm ? dec.imm : rkd_value;

    alu u_alu (
        .alu_op (dec.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    // b, beq, bne and unknown encodings finish in decode.
    assign id_only = dec.op == isa_pkg::op_b || dec.op == isa_pkg::op_beq ||
                     dec.op == isa_pkg::op_bne || dec.op == isa_pkg::op_invalid;
    assign is_mem = dec.op == isa_pkg::op_ld_w || dec.op == isa_pkg::op_st_w;

    always_comb begin
        state_next = state;
        case (state)
            core_pkg::st_if: state_next = core_pkg::st_id;
            core_pkg::st_id: begin
                state_next = id_only ? core_pkg::st_if : core_pkg::st_exe;
            end
            core_pkg::st_exe: begin
                state_next = is_mem ? core_pkg::st_mem : core_pkg::st_wb;
            end
            core_pkg::st_mem: begin
                if (dec.op == isa_pkg::op_ld_w) begin
                    state_next = core_pkg::st_wb;
                end else begin
                    state_next = core_pkg::st_if;
                end
            end
            core_pkg::st_wb: state_next = core_pkg::st_if;
            default: state_next = core_pkg::st_if;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_pkg::st_if;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_pkg::st_if) begin
            ir <= inst_rdata;
        end
    end

    // register values stay put until writeback, so the target is stable in every state.
    assign seq_pc = pc + 32'd4;
    assign br_taken = (dec.op == isa_pkg::op_beq && rj_value == rkd_value) ||
                      (dec.op == isa_pkg::op_bne && rj_value != rkd_value) ||
                      dec.op == isa_pkg::op_b || dec.op == isa_pkg::op_bl ||
                      dec.op == isa_pkg::op_jirl;
    assign br_target = (dec.op == isa_pkg::op_jirl) ? rj_value + dec.br_offs :
                                                      pc + dec.br_offs;
    assign next_pc = br_taken ? br_target : seq_pc;

    // pc moves on in the last state of each instruction.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CPU_RESET_PC;
        end else if (state != core_pkg::st_if && state_next == core_pkg::st_if) begin
            pc <= next_pc;
        end
    end

    assign inst_addr = pc;

    assign data_we = state == core_pkg::st_mem && dec.op == isa_pkg::op_st_w;
    assign data_addr = alu_result;
    assign data_wdata = rkd_value;

    assign wb_value = (dec.op == isa_pkg::op_ld_w) ? data_rdata : alu_result;
    assign rf_we = state == core_pkg::st_wb && dec.writes_rf;

    always_comb begin
        wb_trace.valid = rf_we && dec.dest != '0;
        wb_trace.pc = pc;
        wb_trace.wnum = dec.dest;
        wb_trace.wdata = wb_value;
    end

endmodule

/* dv/tb_core.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module tb_core;

    localparam int CLK_PERIOD = 4;
    localparam int DMEM_WORDS = 256;

    logic                   clk = 1'b0;
    logic                   reset;
    logic [`CPU_XLEN-1:0]   inst_addr;
    logic [`CPU_XLEN-1:0]   inst_rdata;
    logic                   data_we;
    logic [`CPU_XLEN-1:0]   data_addr;
    logic [`CPU_XLEN-1:0]   data_wdata;
    logic [`CPU_XLEN-1:0]   data_rdata;
    core_pkg::wb_trace_t    wb_trace;

    logic [`CPU_XLEN-1:0]   imem[$];
    logic [`CPU_XLEN-1:0]   dmem[DMEM_WORDS];
    core_pkg::wb_trace_t    exp_trace[$];
    int                     exp_gap[$];
    logic [`CPU_XLEN-1:0]   exp_st_addr[$];
    logic [`CPU_XLEN-1:0]   exp_st_data[$];
    int                     trace_idx;
    int                     store_idx;
    int                     value_errs;
    int                     timing_errs;
    int                     missing;
    time                    last_trace_t;

    multicycle_core u_multicycle_core (
        .clk        (clk),
        .reset      (reset),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .wb_trace   (wb_trace)
    );

    // LA32R instruction formats.
    function automatic logic [31:0] rrr_word(logic [4:0] op5, int rd, int rj, int rk);
        return {12'h001, op5, rk[4:0], rj[4:0], rd[4:0]};
    endfunction
    function automatic logic [31:0] shift_word(logic [4:0] op5, int rd, int rj, int ui5);
        return {10'h001, 2'b00, op5, ui5[4:0], rj[4:0], rd[4:0]};
    endfunction
    function automatic logic [31:0] imm12_word(logic [9:0] op10, int rd, int rj, int si12);
        return {op10, si12[11:0], rj[4:0], rd[4:0]};
    endfunction
    function automatic logic [31:0] lu12i_word(int rd, int si20);
        return {7'b0001010, si20[19:0], rd[4:0]};
    endfunction
    // offsets count words.
    function automatic logic [31:0] off16_word(logic [5:0] op6, int rj, int rd, int offs);
        return {op6, offs[15:0], rj[4:0], rd[4:0]};
    endfunction
    function automatic logic [31:0] off26_word(logic [5:0] op6, int offs);
        return {op6, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `CPU_RESET_PC) >> 2;
        if (idx < imem.size()) begin
            return imem[idx];
        end
        return '0;
    endfunction

    // gap counts the cycles since the previous write and 0 skips the check.
    task automatic expect_trace(input int idx, input int wnum, input logic [31:0] wdata,
                                input int gap);
        core_pkg::wb_trace_t t;
        t.valid = 1'b1;
        t.pc = `CPU_RESET_PC + 4 * idx;
        t.wnum = wnum[4:0];
        t.wdata = wdata;
        exp_trace.push_back(t);
        exp_gap.push_back(gap);
    endtask

    task automatic check_trace(input core_pkg::wb_trace_t got, input core_pkg::wb_trace_t exp);
        if (got.pc !== exp.pc || got.wnum !== exp.wnum || got.wdata !== exp.wdata) begin
            value_errs++;
            $display("ERR %0t: write pc %h r%0d = %h, expected pc %h r%0d = %h", $time,
                     got.pc, got.wnum, got.wdata, exp.pc, exp.wnum, exp.wdata);
        end
    endtask

    task automatic check_store(input logic [`CPU_XLEN-1:0] addr, input logic [`CPU_XLEN-1:0] data,
                               input logic [`CPU_XLEN-1:0] exp_addr,
                               input logic [`CPU_XLEN-1:0] exp_data);
        if (addr !== exp_addr || data !== exp_data) begin
            value_errs++;
            $display("ERR %0t: store [%h] = %h, expected [%h] = %h", $time,
                     addr, data, exp_addr, exp_data);
        end
    endtask

    task automatic load_tables();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = ~(i * 4);
        end
        imem.push_back(imm12_word(10'h00a, 1, 0, 'h123));     // 0  addi.w r1, r0, 0x123
        imem.push_back(imm12_word(10'h00a, 2, 0, -5));        // 1  addi.w r2, r0, -5
        imem.push_back(lu12i_word(3, 'h80000));               // 2  lu12i.w r3, 0x80000
        imem.push_back(rrr_word(5'h00, 4, 1, 2));             // 3  add.w
        imem.push_back(rrr_word(5'h02, 5, 1, 2));             // 4  sub.w
        imem.push_back(rrr_word(5'h04, 6, 2, 1));             // 5  slt r6, r2, r1
        imem.push_back(rrr_word(5'h05, 7, 2, 1));             // 6  sltu r7, r2, r1
        imem.push_back(rrr_word(5'h08, 8, 1, 2));             // 7  nor
        imem.push_back(rrr_word(5'h09, 9, 1, 2));             // 8  and
        imem.push_back(rrr_word(5'h0a, 10, 1, 3));            // 9  or r10, r1, r3
        imem.push_back(rrr_word(5'h0b, 11, 1, 2));            // 10 xor
        imem.push_back(shift_word(5'h01, 12, 1, 4));          // 11 slli.w
        imem.push_back(shift_word(5'h09, 13, 3, 4));          // 12 srli.w
        imem.push_back(shift_word(5'h11, 14, 3, 4));          // 13 srai.w
        imem.push_back(imm12_word(10'h00a, 0, 1, 1));         // 14 addi.w r0, r1, 1
        imem.push_back(rrr_word(5'h00, 15, 0, 0));            // 15 add.w r15, r0, r0
        imem.push_back(imm12_word(10'h00a, 16, 0, 'h40));     // 16 addi.w r16, r0, 0x40
        imem.push_back(imm12_word(10'h0a6, 10, 16, 8));       // 17 st.w r10, r16, 8
        imem.push_back(imm12_word(10'h0a2, 17, 16, 8));       // 18 ld.w r17, r16, 8
        imem.push_back(off16_word(6'h16, 1, 9, 2));           // 19 beq taken
        imem.push_back(imm12_word(10'h00a, 18, 0, 'h111));    // 20 skipped
        imem.push_back(off16_word(6'h17, 1, 9, 2));           // 21 bne not taken
        imem.push_back(imm12_word(10'h00a, 18, 0, 'h22));     // 22
        imem.push_back(off16_word(6'h17, 1, 2, 2));           // 23 bne taken
        imem.push_back(imm12_word(10'h00a, 19, 0, 'h333));    // 24 skipped
        imem.push_back(off16_word(6'h16, 1, 2, 2));           // 25 beq not taken
        imem.push_back(off26_word(6'h14, 2));                 // 26 b to 28
        imem.push_back(imm12_word(10'h00a, 19, 0, 'h444));    // 27 skipped
        imem.push_back(off26_word(6'h15, 4));                 // 28 bl to 32
        imem.push_back(imm12_word(10'h00a, 22, 0, 'h666));    // 29 skipped by jirl
        imem.push_back(imm12_word(10'h00a, 20, 0, 'h55));     // 30 reached from jirl
        imem.push_back(off26_word(6'h14, 2));                 // 31 b to 33
        imem.push_back(off16_word(6'h13, 1, 21, 1));          // 32 jirl r21, r1, 1
        imem.push_back(off26_word(6'h14, 0));                 // 33 final loop
        // wb is the fourth cycle, three after the release edge.
        expect_trace(0, 1, 32'h0000_0123, 3);
        expect_trace(1, 2, 32'hffff_fffb, 4);
        expect_trace(2, 3, 32'h8000_0000, 4);
        expect_trace(3, 4, 32'h0000_011e, 4);
        expect_trace(4, 5, 32'h0000_0128, 4);
        expect_trace(5, 6, 32'h0000_0001, 4);
        expect_trace(6, 7, 32'h0000_0000, 4);
        expect_trace(7, 8, 32'h0000_0004, 4);
        expect_trace(8, 9, 32'h0000_0123, 4);
        expect_trace(9, 10, 32'h8000_0123, 4);
        expect_trace(10, 11, 32'hffff_fed8, 4);
        expect_trace(11, 12, 32'h0000_1230, 4);
        expect_trace(12, 13, 32'h0800_0000, 4);
        expect_trace(13, 14, 32'hf800_0000, 4);
        expect_trace(15, 15, 32'h0000_0000, 8);
        expect_trace(16, 16, 32'h0000_0040, 4);
        expect_trace(18, 17, 32'h8000_0123, 9);
        expect_trace(22, 18, 32'h0000_0022, 8);
        expect_trace(28, 1, `CPU_RESET_PC + 32'h74, 10);
        expect_trace(32, 21, `CPU_RESET_PC + 32'h84, 4);
        expect_trace(30, 20, 32'h0000_0055, 4);
        exp_st_addr.push_back(32'h0000_0048);
        exp_st_data.push_back(32'h8000_0123);
    endtask

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // outputs are sampled and memory answers driven on the falling edge.
    always @(negedge clk) begin
        if (reset && (wb_trace.valid !== 1'b0 || data_we !== 1'b0)) begin
            value_errs++;
            $display("ERR %0t: write or store seen during reset", $time);
        end else if (!reset) begin
            if (data_we === 1'b1) begin
                if (store_idx < exp_st_addr.size()) begin
                    check_store(data_addr, data_wdata, exp_st_addr[store_idx],
                                exp_st_data[store_idx]);
                end else begin
                    value_errs++;
                    $display("ERR %0t: unexpected store [%h] = %h", $time, data_addr, data_wdata);
                end
                store_idx++;
                dmem[data_addr[9:2]] = data_wdata;
            end
            if (wb_trace.valid === 1'b1) begin
                if (trace_idx < exp_trace.size()) begin
                    check_trace(wb_trace, exp_trace[trace_idx]);
                    if (exp_gap[trace_idx] != 0 &&
                        $time - last_trace_t != exp_gap[trace_idx] * CLK_PERIOD) begin
                        timing_errs++;
                        $display("ERR %0t: write %0d came %0t ns after the last, expected %0d cycles",
                                 $time, trace_idx, $time - last_trace_t, exp_gap[trace_idx]);
                    end
                end else begin
                    value_errs++;
                    $display("ERR %0t: unexpected write r%0d = %h", $time, wb_trace.wnum,
                             wb_trace.wdata);
                end
                trace_idx++;
                last_trace_t = $time;
            end
        end
        inst_rdata <= fetch_word(inst_addr);
        data_rdata <= dmem[data_addr[9:2]];
    end

    initial begin
        reset = 1'b1;
        inst_rdata = '0;
        data_rdata = '0;
        trace_idx = 0;
        store_idx = 0;
        value_errs = 0;
        timing_errs = 0;
        missing = 0;
        load_tables();
        fork
            begin
                #(5 * CLK_PERIOD * imem.size() + 200);
                $display("timeout: the program never reached its final loop");
                $display("TEST RESULT: FAIL");
                $finish;
            end
        join_none
        repeat (8) @(negedge clk);
        reset <= 1'b0;
        last_trace_t = $time;
        while (inst_addr !== `CPU_RESET_PC + 32'h84) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (trace_idx < exp_trace.size()) begin
            missing += exp_trace.size() - trace_idx;
        end
        if (store_idx < exp_st_addr.size()) begin
            missing += exp_st_addr.size() - store_idx;
        end
        if (missing != 0) begin
            $display("missing results: saw %0d of %0d register writes and %0d of %0d stores",
                     trace_idx, exp_trace.size(), store_idx, exp_st_addr.size());
        end
        $display("errors: value %0d, timing %0d, missing %0d", value_errs, timing_errs, missing);
        if (value_errs == 0 && timing_errs == 0 && missing == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/alu.sv
rtl/multicycle_core.sv
dv/tb_core.sv

/* Bender.yml */
package:
  name: multicycle_core

export_include_dirs:
  - rtl

sources:
  - rtl/isa_pkg.sv
  - rtl/core_pkg.sv
  - rtl/inst_decoder.sv
  - rtl/regfile.sv
  - rtl/alu.sv
  - rtl/multicycle_core.sv
  - target: simulation
    files:
      - dv/tb_core.sv
